//--- hw/match_engine.sv
`timescale 1ns/1ps

module match_engine (
    input  logic                                clk,
    input  logic                                rstn,
    input  tanimoto_pkg::in_beat_t              i_vec,
    input  tanimoto_pkg::thr_wr_t               i_thr,
    input  logic                                i_run_done,
    input  logic [tanimoto_pkg::FIFO_CNT_W-1:0] i_fifo_count,
    output logic                                o_read,
    output tanimoto_pkg::match_rec_t            o_rec,
    output logic                                o_rec_wr
);

    tanimoto_pkg::run_state_e                 state;
    logic [$clog2(tanimoto_pkg::REF_NUM)-1:0] ref_idx;
    logic [tanimoto_pkg::ID_W-1:0]            cmp_num;

    logic [tanimoto_pkg::VEC_W-1:0] ref_vec [tanimoto_pkg::REF_NUM];
    logic [tanimoto_pkg::CNT_W-1:0] ref_cnt [tanimoto_pkg::REF_NUM];
    logic [tanimoto_pkg::THR_W-1:0] thr_tab [tanimoto_pkg::VEC_W+1];

    logic                           accept;
    logic [tanimoto_pkg::CNT_W-1:0] in_cnt;
    logic [tanimoto_pkg::CNT_W-1:0] and_cnt [tanimoto_pkg::REF_NUM];

    logic                           s1_vld;
    logic                           s1_last;
    logic [tanimoto_pkg::CNT_W-1:0] s1_b;
    logic [tanimoto_pkg::CNT_W-1:0] s1_c [tanimoto_pkg::REF_NUM];
    logic [tanimoto_pkg::ID_W-1:0]  s1_id;
    logic [tanimoto_pkg::REF_NUM-1:0] mask;

    // Leave room in the FIFO for the two records still in the pipeline
    assign o_read = (state == tanimoto_pkg::LOAD_REF) ||
                    (state == tanimoto_pkg::COMPARE && i_fifo_count <= tanimoto_pkg::RD_LIMIT);
    assign accept = i_vec.valid && o_read;

    // Shared counter gives a while loading and b while comparing
    popcount u_pop_in (
        .i_vec (i_vec.data),
        .o_cnt (in_cnt)
    );

    for (genvar k = 0; k < tanimoto_pkg::REF_NUM; k++) begin : g_and
        popcount u_pop_and (
            .i_vec (i_vec.data & ref_vec[k]),
            .o_cnt (and_cnt[k])
        );
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= tanimoto_pkg::LOAD_REF;
            ref_idx <= '0;
            cmp_num <= '0;
        end else begin
            case (state)
                tanimoto_pkg::LOAD_REF: begin
                    if (accept) begin
                        ref_idx <= ref_idx + 1'b1;
                        // All ones means the fourth reference just arrived
                        if (ref_idx == '1) begin
                            state <= tanimoto_pkg::COMPARE;
                        end
                    end
                end
                tanimoto_pkg::COMPARE: begin
                    if (accept) begin
                        cmp_num <= cmp_num + 1'b1;
                        if (i_vec.last) begin
                            state <= tanimoto_pkg::DRAIN;
                        end
                    end
                end
                default: begin
                    if (i_run_done) begin
                        state   <= tanimoto_pkg::LOAD_REF;
                        ref_idx <= '0;
                        cmp_num <= '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == tanimoto_pkg::LOAD_REF) begin
            ref_vec[ref_idx] <= i_vec.data;
            ref_cnt[ref_idx] <= in_cnt;
        end
    end

    // Host writes land in any state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i <= tanimoto_pkg::VEC_W; i++) begin
                thr_tab[i] <= '0;
            end
        end else if (i_thr.en) begin
            thr_tab[i_thr.addr] <= i_thr.data;
        end
    end

    // Stage one
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= accept && state == tanimoto_pkg::COMPARE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_b    <= in_cnt;
            s1_c    <= and_cnt;
            s1_id   <= cmp_num + tanimoto_pkg::FIRST_CMP_ID;
            s1_last <= i_vec.last;
        end
    end

    // Stage two matches when a + b fits under the entry for c
    always_comb begin
        for (int k = 0; k < tanimoto_pkg::REF_NUM; k++) begin
            mask[k] = ({1'b0, ref_cnt[k]} + {1'b0, s1_b}) <= thr_tab[s1_c[k]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_rec_wr <= 1'b0;
        end else begin
            o_rec_wr <= s1_vld && ((|mask) || s1_last);
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            o_rec.mask   <= mask;
            o_rec.cmp_id <= s1_id;
            o_rec.last   <= s1_last;
        end
    end

    a_thr_addr: assert property (@(posedge clk) disable iff (!rstn)
        i_thr.en |-> i_thr.addr <= tanimoto_pkg::VEC_W);

    // Holds only if the read limit covers the in-flight records
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        o_rec_wr |-> i_fifo_count != tanimoto_pkg::FIFO_FULL);

endmodule

//--- hw/match_fifo.sv
`timescale 1ns/1ps

module match_fifo (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                i_wr,
    input  tanimoto_pkg::match_rec_t            i_rec,
    input  logic                                i_pop,
    output tanimoto_pkg::match_rec_t            o_rec,
    output logic                                o_nempty,
    output logic [tanimoto_pkg::FIFO_CNT_W-1:0] o_count
);

    tanimoto_pkg::match_rec_t mem [tanimoto_pkg::FIFO_DEPTH];

    // Depth is a power of two so the pointers wrap on their own
    logic [$clog2(tanimoto_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(tanimoto_pkg::FIFO_DEPTH)-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_wr, i_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
        end
    end

    // Head is shown without a read request
    assign o_rec    = mem[rd_ptr];
    assign o_nempty = (o_count != '0);

    a_no_write_full: assert property (@(posedge clk) disable iff (!rstn)
        i_wr |-> o_count != tanimoto_pkg::FIFO_FULL);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        i_pop |-> o_nempty);

endmodule

//--- hw/pair_emitter.sv
`timescale 1ns/1ps

module pair_emitter (
    input  logic                     clk,
    input  logic                     rstn,
    input  tanimoto_pkg::match_rec_t i_rec,
    input  logic                     i_nempty,
    output logic                     o_pop,
    input  logic                     i_pair_read,
    output tanimoto_pkg::id_pair_t   o_pair,
    output logic                     o_pair_valid,
    output logic                     o_pair_last,
    output logic                     o_run_done
);

    logic [tanimoto_pkg::REF_NUM-1:0] work_mask;
    logic [tanimoto_pkg::REF_NUM-1:0] next_mask;
    logic                             work_vld;
    logic                             end_vld;
    logic [tanimoto_pkg::ID_W-1:0]    low_idx;

    // Lowest set bit of the working mask is the next reference
    always_comb begin
        low_idx = '0;
        for (int k = tanimoto_pkg::REF_NUM - 1; k >= 0; k--) begin
            if (work_mask[k]) begin
                low_idx = k[tanimoto_pkg::ID_W-1:0];
            end
        end
    end

    assign next_mask = work_mask & (work_mask - 1'b1);

    // A last record with an empty mask is dropped at once
    assign o_pop = work_vld && (next_mask == '0) && ((work_mask == '0) || i_pair_read);

    assign o_pair_valid = (work_vld && (work_mask != '0)) || end_vld;
    assign o_pair_last  = end_vld;
    assign o_pair       = end_vld ? '0 : {low_idx, i_rec.cmp_id};
    assign o_run_done   = end_vld && i_pair_read;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            work_vld <= 1'b0;
            end_vld  <= 1'b0;
        end else if (end_vld) begin
            if (i_pair_read) begin
                end_vld <= 1'b0;
            end
        end else if (work_vld) begin
            if (o_pop) begin
                work_vld <= 1'b0;
                end_vld  <= i_rec.last;
            end
        end else if (i_nempty) begin
            work_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!work_vld && !end_vld && i_nempty) begin
            work_mask <= i_rec.mask;
        end else if (work_vld && i_pair_read) begin
            work_mask <= next_mask;
        end
    end

    a_pair_stable: assert property (@(posedge clk) disable iff (!rstn)
        (o_pair_valid && !i_pair_read) |=> $stable(o_pair));

endmodule

//--- hw/popcount.sv
`timescale 1ns/1ps

module popcount (
    input  logic [tanimoto_pkg::VEC_W-1:0] i_vec,
    output logic [tanimoto_pkg::CNT_W-1:0] o_cnt
);

    // Each level adds neighbouring sums, one bit wider than the level before
    logic [1:0] sum1 [tanimoto_pkg::VEC_W/2];
    logic [2:0] sum2 [tanimoto_pkg::VEC_W/4];
    logic [3:0] sum3 [tanimoto_pkg::VEC_W/8];
    logic [4:0] sum4 [tanimoto_pkg::VEC_W/16];

    for (genvar i = 0; i < tanimoto_pkg::VEC_W/2; i++) begin : g_lvl1
        assign sum1[i] = {1'b0, i_vec[2*i]} + {1'b0, i_vec[2*i+1]};
    end

    for (genvar i = 0; i < tanimoto_pkg::VEC_W/4; i++) begin : g_lvl2
        assign sum2[i] = {1'b0, sum1[2*i]} + {1'b0, sum1[2*i+1]};
    end

    for (genvar i = 0; i < tanimoto_pkg::VEC_W/8; i++) begin : g_lvl3
        assign sum3[i] = {1'b0, sum2[2*i]} + {1'b0, sum2[2*i+1]};
    end

    for (genvar i = 0; i < tanimoto_pkg::VEC_W/16; i++) begin : g_lvl4
        assign sum4[i] = {1'b0, sum3[2*i]} + {1'b0, sum3[2*i+1]};
    end

    // Root of the tree
    assign o_cnt = {1'b0, sum4[0]} + {1'b0, sum4[1]};

endmodule

//--- hw/tanimoto_pkg.sv
package tanimoto_pkg;

    // Vector and count widths
    localparam int VEC_W      = 32;
    localparam int CNT_W      = 6;
    localparam int REF_NUM    = 4;
    localparam int ID_W       = 8;
    // a + b can reach 64
    localparam int THR_W      = 7;

    // Match record buffer
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_CNT_W = 4;
    localparam int PIPE_SLACK = 2;

    localparam logic [FIFO_CNT_W-1:0] FIFO_FULL    = FIFO_CNT_W'(FIFO_DEPTH);
    // Highest occupancy at which new input is still taken
    localparam logic [FIFO_CNT_W-1:0] RD_LIMIT     = FIFO_CNT_W'(FIFO_DEPTH - PIPE_SLACK - 1);
    // Compare IDs start right after the reference IDs
    localparam logic [ID_W-1:0]       FIRST_CMP_ID = ID_W'(REF_NUM);

    typedef enum logic [1:0] {
        LOAD_REF = 2'd0,
        COMPARE  = 2'd1,
        DRAIN    = 2'd2
    } run_state_e;

    typedef struct packed {
        logic [VEC_W-1:0] data;
        logic             valid;
        logic             last;
    } in_beat_t;

    typedef struct packed {
        logic [CNT_W-1:0] addr;
        logic [THR_W-1:0] data;
        logic             en;
    } thr_wr_t;

    typedef struct packed {
        logic [REF_NUM-1:0] mask;
        logic [ID_W-1:0]    cmp_id;
        logic               last;
    } match_rec_t;

    typedef struct packed {
        logic [ID_W-1:0] ref_id;
        logic [ID_W-1:0] cmp_id;
    } id_pair_t;

endpackage

//--- hw/tanimoto_top.sv
`timescale 1ns/1ps

module tanimoto_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  tanimoto_pkg::in_beat_t i_vec,
    input  tanimoto_pkg::thr_wr_t  i_thr,
    output logic                   o_read,
    input  logic                   i_pair_read,
    output tanimoto_pkg::id_pair_t o_pair,
    output logic                   o_pair_valid,
    output logic                   o_pair_last
);

    tanimoto_pkg::match_rec_t            eng_rec;
    logic                                eng_rec_wr;
    tanimoto_pkg::match_rec_t            head_rec;
    logic                                head_nempty;
    logic [tanimoto_pkg::FIFO_CNT_W-1:0] fifo_count;
    logic                                fifo_pop;
    logic                                run_done;

    match_engine u_match_engine (
        .clk          (clk),
        .rstn         (rstn),
        .i_vec        (i_vec),
        .i_thr        (i_thr),
        .i_run_done   (run_done),
        .i_fifo_count (fifo_count),
        .o_read       (o_read),
        .o_rec        (eng_rec),
        .o_rec_wr     (eng_rec_wr)
    );

    match_fifo u_match_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .i_wr     (eng_rec_wr),
        .i_rec    (eng_rec),
        .i_pop    (fifo_pop),
        .o_rec    (head_rec),
        .o_nempty (head_nempty),
        .o_count  (fifo_count)
    );

    // Reading the run-end beat sends the engine back to loading
    pair_emitter u_pair_emitter (
        .clk          (clk),
        .rstn         (rstn),
        .i_rec        (head_rec),
        .i_nempty     (head_nempty),
        .o_pop        (fifo_pop),
        .i_pair_read  (i_pair_read),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .o_pair_last  (o_pair_last),
        .o_run_done   (run_done)
    );

endmodule

//--- project.f
hw/tanimoto_pkg.sv
hw/popcount.sv
hw/match_engine.sv
hw/match_fifo.sv
hw/pair_emitter.sv
hw/tanimoto_top.sv
verification/tanimoto_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tanimoto_tb -o tanimoto_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tanimoto_sim > "$LOG"
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/tanimoto_tb.sv
`timescale 1ns/1ps

module tanimoto_tb;

    typedef struct packed {
        logic                   last;
        tanimoto_pkg::id_pair_t pair;
    } exp_beat_t;

    localparam int WAIT_LIMIT = 400;

    logic                   clk;
    logic                   rstn;
    tanimoto_pkg::in_beat_t i_vec;
    tanimoto_pkg::thr_wr_t  i_thr;
    logic                   o_read;
    logic                   i_pair_read;
    tanimoto_pkg::id_pair_t o_pair;
    logic                   o_pair_valid;
    logic                   o_pair_last;

    logic [31:0] lfsr;
    logic [31:0] ref_model [4];
    int          thr_model [33];
    logic [7:0]  next_cmp_id;
    exp_beat_t   exp_q [$];
    exp_beat_t   exp_beat;
    logic        exp_none;
    logic        read_hold;
    logic        stall_chk;
    int          err_cnt;
    int          timeouts;
    int          read_cnt;
    int          runs_done;
    int          tests_run;

    tanimoto_top tanimoto_top_inst (.*);

    always #50 clk = ~clk;

    a_reset_state: assert property (@(posedge clk) $rose(rstn) |->
        o_read && !o_pair_valid && !o_pair_last)
        else begin
            $display("ERR after reset o_read %h o_pair_valid %h o_pair_last %h",
                     $sampled(o_read), $sampled(o_pair_valid), $sampled(o_pair_last));
            err_cnt++;
        end

    a_pair_value: assert property (@(posedge clk) disable iff (!rstn)
        (o_pair_valid && i_pair_read && !exp_none) |-> o_pair == exp_beat.pair)
        else begin
            $display("ERR o_pair %h expected %h", $sampled(o_pair), exp_beat.pair);
            err_cnt++;
        end

    a_last_value: assert property (@(posedge clk) disable iff (!rstn)
        (o_pair_valid && i_pair_read && !exp_none) |-> o_pair_last == exp_beat.last)
        else begin
            $display("ERR o_pair_last %h expected %h", $sampled(o_pair_last), exp_beat.last);
            err_cnt++;
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!rstn)
        (o_pair_valid && i_pair_read) |-> !exp_none)
        else begin
            $display("Output beat %h read when no beat was expected", $sampled(o_pair));
            err_cnt++;
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
        (o_pair_valid && !i_pair_read) |=> $stable(o_pair) && $stable(o_pair_last))
        else begin
            $display("ERR o_pair changed to %h while not read", $sampled(o_pair));
            err_cnt++;
        end

    a_back_pressure: assert property (@(posedge clk) disable iff (!rstn)
        stall_chk |-> !o_read)
        else begin
            $display("ERR o_read %h expected 0 with output stalled", $sampled(o_read));
            err_cnt++;
        end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic end_run();
        $display("tests %0d, beats read %0d, errors %0d", tests_run, read_cnt,
                 err_cnt + timeouts);
        if (err_cnt + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic time_out(input string what);
        $display("Timed out waiting for %s", what);
        timeouts++;
    endtask

    task automatic report(input string name, input int errs_before);
        tests_run++;
        if (err_cnt + timeouts == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name,
                     err_cnt + timeouts - errs_before);
        end
    endtask

    // Reads every valid beat unless held, and lines up the expected one
    task automatic read_beats();
        forever begin
            @(negedge clk);
            if (rstn && o_pair_valid && !read_hold) begin
                i_pair_read = 1'b1;
                exp_none    = (exp_q.size() == 0);
                if (!exp_none) begin
                    exp_beat = exp_q.pop_front();
                end
                read_cnt++;
                if (o_pair_last) begin
                    runs_done++;
                end
            end else begin
                i_pair_read = 1'b0;
            end
        end
    endtask

    task automatic send_beat(input logic [31:0] vec, input logic last);
        int waited;
        i_vec  = {vec, 1'b1, last};
        waited = 0;
        while (!o_read && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_read) begin
            time_out("input acceptance");
        end else begin
            @(negedge clk);
            i_vec.valid = 1'b0;
        end
    endtask

    task automatic send_compare(input logic [31:0] vec, input logic last);
        int        a;
        int        c;
        exp_beat_t e;
        send_beat(vec, last);
        for (int k = 0; k < 4; k++) begin
            a = $countones(ref_model[k]);
            c = $countones(ref_model[k] & vec);
            if (a + $countones(vec) <= thr_model[c]) begin
                e = {1'b0, k[7:0], next_cmp_id};
                exp_q.push_back(e);
            end
        end
        // Run-end beat carries zero data
        if (last) begin
            e = {1'b1, 16'h0000};
            exp_q.push_back(e);
        end
        next_cmp_id++;
    endtask

    task automatic do_run(input int n_cmp, input logic copies_only);
        logic [31:0] v;
        logic [31:0] pick;
        logic [31:0] sel;
        for (int k = 0; k < 4; k++) begin
            take_bits(32, v);
            ref_model[k] = v;
            send_beat(v, 1'b0);
        end
        next_cmp_id = 8'd4;
        for (int i = 0; i < n_cmp; i++) begin
            take_bits(2, pick);
            take_bits(2, sel);
            // Exact copies of a reference make sure matches occur
            if (copies_only || sel == 0) begin
                v = ref_model[pick[1:0]];
            end else begin
                take_bits(32, v);
            end
            send_compare(v, i == n_cmp - 1);
        end
    endtask

    task automatic wait_run_end(input int target);
        int waited;
        waited = 0;
        while (runs_done < target && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (runs_done < target) begin
            time_out("the run-end beat");
        end
    endtask

    initial begin
        int errs;
        clk         = 1'b0;
        rstn        = 1'b0;
        i_vec       = '0;
        i_thr       = '0;
        i_pair_read = 1'b0;
        read_hold   = 1'b0;
        stall_chk   = 1'b0;
        exp_none    = 1'b0;
        exp_beat    = '0;
        lfsr        = 32'h25463d5b;
        err_cnt     = 0;
        timeouts    = 0;
        read_cnt    = 0;
        runs_done   = 0;
        tests_run   = 0;
        fork
            read_beats();
        join_none
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        report("reset state", 0);

        fork
            begin
                errs = err_cnt + timeouts;
                // Similarity of at least 0.4 gives a + b <= 3.5 c
                for (int c = 0; c <= 32; c++) begin
                    thr_model[c] = (7 * c) / 2;
                    i_thr        = {c[5:0], 7'(thr_model[c]), 1'b1};
                    @(negedge clk);
                end
                i_thr.en = 1'b0;
                do_run(40, 1'b0);
                wait_run_end(1);
                report("random compare against model", errs);

                errs = err_cnt + timeouts;
                repeat (20) @(negedge clk);
                report("single run-end beat", errs);

                errs = err_cnt + timeouts;
                do_run(12, 1'b0);
                wait_run_end(2);
                report("second run with IDs from 4", errs);

                errs      = err_cnt + timeouts;
                read_hold = 1'b1;
                fork
                    do_run(16, 1'b1);
                    begin
                        repeat (60) @(negedge clk);
                        stall_chk = 1'b1;
                        @(negedge clk);
                        stall_chk = 1'b0;
                        read_hold = 1'b0;
                    end
                join
                wait_run_end(3);
                report("output stall", errs);
            end
            // Any timeout cuts the test sequence short
            wait (timeouts != 0);
        join_any
        end_run();
    end

endmodule
